//--- hdl/e100_pkg.sv
// e100 shared definitions: word and address types, opcodes, sequencer states, bus sources
`default_nettype none

package e100_pkg;

    // data path and memory geometry
    localparam int word_width = 32;
    localparam int address_width = 8;
    localparam int memory_words = 1 << address_width;

    // opcode, arg1, arg2, arg3
    localparam int instruction_words = 4;

    typedef logic [word_width-1:0] word_t;
    typedef logic [address_width-1:0] address_t;

    // reference numbering, gaps are the opcodes this machine does not run
    typedef enum logic [word_width-1:0] {
        op_halt = 32'd0,
        op_add  = 32'd1,
        op_sub  = 32'd2,
        op_cp   = 32'd5,
        op_and  = 32'd6,
        op_or   = 32'd7,
        op_not  = 32'd8,
        op_sl   = 32'd9,
        op_sr   = 32'd10,
        op_be   = 32'd13,
        op_bne  = 32'd14,
        op_blt  = 32'd15
    } opcode_t;

    typedef enum logic [4:0] {
        state_idle,
        state_fetch1, state_fetch2, state_fetch3, state_fetch4,
        state_fetch5, state_fetch6, state_fetch7, state_fetch8,
        state_decode,
        state_halt,
        // shared by add, sub, and, or, sl, sr
        state_exec1, state_exec2, state_exec3,
        state_exec4, state_exec5, state_exec6,
        state_not1, state_not2, state_not3, state_not4,
        state_cp1, state_cp2, state_cp3, state_cp4,
        // shared by be, bne, blt
        state_branch1, state_branch2, state_branch3,
        state_branch4, state_branch5, state_branch6
    } state_t;

    // what drives the shared bus this cycle
    typedef enum logic [2:0] {
        src_none,
        src_iar,
        src_plus1,
        src_arg1,
        src_arg2,
        src_arg3,
        src_memory,
        src_alu
    } bus_source_t;

endpackage

`default_nettype wire

//--- hdl/e100_memory.sv
// e100 memory side: word memory, address register and host load/readback port
`timescale 1ns/1ps
`default_nettype none

module e100_memory (
    input  logic              clock,
    input  logic              reset,
    input  logic              halted,
    input  e100_pkg::word_t    bus,
    input  logic              address_write,
    input  logic              memory_write,
    input  logic              host_write,
    input  e100_pkg::address_t host_address,
    input  e100_pkg::word_t    host_write_data,
    output e100_pkg::word_t    memory_data,
    output e100_pkg::word_t    host_read_data
);

    import e100_pkg::*;

    word_t    words [memory_words];
    address_t address_reg;
    logic     host_write_ok;

    // host may only touch memory while the processor is stopped
    assign host_write_ok = halted && host_write;

    // address register, loaded from the low bits of the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            address_reg <= '0;
        end else if (address_write) begin
            address_reg <= bus[address_width-1:0];
        end
    end

    // processor store has the port when running, host when halted
    always_ff @(posedge clock) begin
        if (memory_write) begin
            words[address_reg] <= bus;
        end else if (host_write_ok) begin
            words[host_address] <= host_write_data;
        end
    end

    // both reads are combinational
    assign memory_data = words[address_reg];
    assign host_read_data = words[host_address];

endmodule

`default_nettype wire

//--- hdl/e100_control.sv
// e100 sequencer: fetch, decode and execute FSM driving bus source and write enables
`timescale 1ns/1ps
`default_nettype none

module e100_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  e100_pkg::word_t         opcode,
    input  logic                   equal,
    input  logic                   less,
    output e100_pkg::bus_source_t   bus_source,
    output logic                   iar_write,
    output logic                   opcode_write,
    output logic                   arg1_write,
    output logic                   arg2_write,
    output logic                   arg3_write,
    output logic                   op1_write,
    output logic                   op2_write,
    output logic                   address_write,
    output logic                   memory_write,
    output logic                   clear_iar,
    output logic                   halted
);

    import e100_pkg::*;

    state_t state;
    state_t next_state;
    logic   take_branch;

    assign halted = (state == state_idle) || (state == state_halt);

    // start only counts while stopped, and restarts at address 0
    assign clear_iar = halted && start;

    always_comb begin
        case (opcode)
            op_be:   take_branch = equal;
            op_bne:  take_branch = !equal;
            op_blt:  take_branch = less;
            default: take_branch = 1'b0;
        endcase
    end

    // bus transfers, grouped by the move each state makes
    always_comb begin
        bus_source = src_none;
        iar_write = 1'b0;
        opcode_write = 1'b0;
        arg1_write = 1'b0;
        arg2_write = 1'b0;
        arg3_write = 1'b0;
        op1_write = 1'b0;
        op2_write = 1'b0;
        address_write = 1'b0;
        memory_write = 1'b0;

        case (state)
            state_fetch1: begin
                bus_source = src_iar;
                address_write = 1'b1;
            end
            // step iar and point memory at the next word
            state_fetch3, state_fetch5, state_fetch7: begin
                bus_source = src_plus1;
                iar_write = 1'b1;
                address_write = 1'b1;
            end
            state_fetch2: begin
                bus_source = src_memory;
                opcode_write = 1'b1;
            end
            state_fetch4: begin
                bus_source = src_memory;
                arg1_write = 1'b1;
            end
            state_fetch6: begin
                bus_source = src_memory;
                arg2_write = 1'b1;
            end
            state_fetch8: begin
                bus_source = src_memory;
                arg3_write = 1'b1;
            end
            // iar now holds the probable next instruction
            state_decode: begin
                bus_source = src_plus1;
                iar_write = 1'b1;
            end
            state_exec1, state_not1, state_cp1, state_branch1: begin
                bus_source = src_arg2;
                address_write = 1'b1;
            end
            state_exec2, state_not2, state_branch2: begin
                bus_source = src_memory;
                op1_write = 1'b1;
            end
            state_exec3, state_branch3: begin
                bus_source = src_arg3;
                address_write = 1'b1;
            end
            state_exec4, state_branch4: begin
                bus_source = src_memory;
                op2_write = 1'b1;
            end
            state_exec5, state_not3, state_cp3: begin
                bus_source = src_arg1;
                address_write = 1'b1;
            end
            state_exec6, state_not4: begin
                bus_source = src_alu;
                memory_write = 1'b1;
            end
            // arg3 is free after decode, so cp parks the word there
            state_cp2: begin
                bus_source = src_memory;
                arg3_write = 1'b1;
            end
            state_cp4: begin
                bus_source = src_arg3;
                memory_write = 1'b1;
            end
            state_branch6: begin
                bus_source = src_arg1;
                iar_write = 1'b1;
            end
            default: begin
                bus_source = src_none;
            end
        endcase
    end

    always_comb begin
        case (state)
            state_idle, state_halt: next_state = start ? state_fetch1 : state;
            state_fetch1: next_state = state_fetch2;
            state_fetch2: next_state = state_fetch3;
            state_fetch3: next_state = state_fetch4;
            state_fetch4: next_state = state_fetch5;
            state_fetch5: next_state = state_fetch6;
            state_fetch6: next_state = state_fetch7;
            state_fetch7: next_state = state_fetch8;
            state_fetch8: next_state = state_decode;
            state_decode: begin
                case (opcode)
                    op_add, op_sub, op_and, op_or, op_sl, op_sr: next_state = state_exec1;
                    op_not: next_state = state_not1;
                    op_cp: next_state = state_cp1;
                    op_be, op_bne, op_blt: next_state = state_branch1;
                    // halt and anything undefined
                    default: next_state = state_halt;
                endcase
            end
            state_exec1: next_state = state_exec2;
            state_exec2: next_state = state_exec3;
            state_exec3: next_state = state_exec4;
            state_exec4: next_state = state_exec5;
            state_exec5: next_state = state_exec6;
            state_not1: next_state = state_not2;
            state_not2: next_state = state_not3;
            state_not3: next_state = state_not4;
            state_cp1: next_state = state_cp2;
            state_cp2: next_state = state_cp3;
            state_cp3: next_state = state_cp4;
            state_branch1: next_state = state_branch2;
            state_branch2: next_state = state_branch3;
            state_branch3: next_state = state_branch4;
            state_branch4: next_state = state_branch5;
            state_branch5: next_state = take_branch ? state_branch6 : state_fetch1;
            default: next_state = state_fetch1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- hdl/e100_datapath.sv
// e100 datapath: iar, instruction and operand registers, ALU, comparators, bus mux
`timescale 1ns/1ps
`default_nettype none

module e100_datapath (
    input  logic                   clock,
    input  logic                   reset,
    input  e100_pkg::bus_source_t   bus_source,
    input  logic                   iar_write,
    input  logic                   opcode_write,
    input  logic                   arg1_write,
    input  logic                   arg2_write,
    input  logic                   arg3_write,
    input  logic                   op1_write,
    input  logic                   op2_write,
    input  logic                   clear_iar,
    input  e100_pkg::word_t         memory_data,
    output e100_pkg::word_t         bus,
    output e100_pkg::word_t         opcode,
    output logic                   equal,
    output logic                   less
);

    import e100_pkg::*;

    word_t iar;
    word_t plus1;
    word_t op1;
    word_t op2;
    word_t alu_result;

    // opcode, arg1, arg2, arg3 in fetch order
    word_t                        instr_regs [instruction_words];
    logic [instruction_words-1:0] instr_write;

    assign instr_write = {arg3_write, arg2_write, arg1_write, opcode_write};
    assign opcode = instr_regs[0];

    // instruction address register
    always_ff @(posedge clock) begin
        if (reset || clear_iar) begin
            iar <= '0;
        end else if (iar_write) begin
            iar <= bus;
        end
    end

    assign plus1 = iar + 1'b1;

    always_ff @(posedge clock) begin
        for (int i = 0; i < instruction_words; i++) begin
            if (instr_write[i]) begin
                instr_regs[i] <= bus;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (op1_write) begin
            op1 <= bus;
        end
        if (op2_write) begin
            op2 <= bus;
        end
    end

    // function picked by the opcode register, not by the sequencer
    always_comb begin
        case (opcode)
            op_add:  alu_result = op1 + op2;
            op_sub:  alu_result = op1 - op2;
            op_and:  alu_result = op1 & op2;
            op_or:   alu_result = op1 | op2;
            op_not:  alu_result = ~op1;
            // full 32-bit shift amount, 32 and up shifts everything out
            op_sl:   alu_result = op1 << op2;
            op_sr:   alu_result = op1 >> op2;
            default: alu_result = op1;
        endcase
    end

    // unsigned compare for blt
    assign equal = (op1 == op2);
    assign less = (op1 < op2);

    always_comb begin
        case (bus_source)
            src_iar:    bus = iar;
            src_plus1:  bus = plus1;
            src_arg1:   bus = instr_regs[1];
            src_arg2:   bus = instr_regs[2];
            src_arg3:   bus = instr_regs[3];
            src_memory: bus = memory_data;
            src_alu:    bus = alu_result;
            default:    bus = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/e100_top.sv
// e100 processor top: memory side, sequencer and datapath on one shared bus
`timescale 1ns/1ps
`default_nettype none

module e100_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  logic              host_write,
    input  e100_pkg::address_t host_address,
    input  e100_pkg::word_t    host_write_data,
    output e100_pkg::word_t    host_read_data,
    output logic              halted
);

    import e100_pkg::*;

    bus_source_t bus_source;
    word_t       bus;
    word_t       memory_data;
    word_t       opcode;
    logic        equal;
    logic        less;

    // write enables from the sequencer
    logic iar_write;
    logic opcode_write;
    logic arg1_write;
    logic arg2_write;
    logic arg3_write;
    logic op1_write;
    logic op2_write;
    logic address_write;
    logic memory_write;
    logic clear_iar;

    e100_memory memory_inst (
        .clock           (clock),
        .reset           (reset),
        .halted          (halted),
        .bus             (bus),
        .address_write   (address_write),
        .memory_write    (memory_write),
        .host_write      (host_write),
        .host_address    (host_address),
        .host_write_data (host_write_data),
        .memory_data     (memory_data),
        .host_read_data  (host_read_data)
    );

    e100_control control_inst (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .opcode        (opcode),
        .equal         (equal),
        .less          (less),
        .bus_source    (bus_source),
        .iar_write     (iar_write),
        .opcode_write  (opcode_write),
        .arg1_write    (arg1_write),
        .arg2_write    (arg2_write),
        .arg3_write    (arg3_write),
        .op1_write     (op1_write),
        .op2_write     (op2_write),
        .address_write (address_write),
        .memory_write  (memory_write),
        .clear_iar     (clear_iar),
        .halted        (halted)
    );

    e100_datapath datapath_inst (
        .clock        (clock),
        .reset        (reset),
        .bus_source   (bus_source),
        .iar_write    (iar_write),
        .opcode_write (opcode_write),
        .arg1_write   (arg1_write),
        .arg2_write   (arg2_write),
        .arg3_write   (arg3_write),
        .op1_write    (op1_write),
        .op2_write    (op2_write),
        .clear_iar    (clear_iar),
        .memory_data  (memory_data),
        .bus          (bus),
        .opcode       (opcode),
        .equal        (equal),
        .less         (less)
    );

endmodule

`default_nettype wire

//--- test/e100_clock_gen.sv
// e100 testbench clock and reset source, 20 ns period with reset held for 4 cycles
`timescale 1ns/1ps
`default_nettype none

module e100_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // release just after the fourth rising edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- test/e100_checker.sv
// e100 sequencer checker: assertions on reset state, halted stores, decode and start
`timescale 1ns/1ps
`default_nettype none

module e100_checker (
    input logic             clock,
    input logic             reset,
    input logic             start,
    input logic             halted,
    input logic             memory_write,
    input e100_pkg::state_t state
);

    import e100_pkg::*;

    // sync reset lands the FSM in idle
    halted_after_reset: assert property (@(posedge clock) reset |=> halted)
        else $error("halted low in the cycle after reset");

    no_store_while_halted: assert property (
        @(posedge clock) disable iff (reset) !(memory_write && halted))
        else $error("memory_write active while halted");

    one_sequence_after_decode: assert property (
        @(posedge clock) disable iff (reset)
        (state == state_decode) |=> $onehot({state == state_exec1, state == state_not1,
            state == state_cp1, state == state_branch1, state == state_halt}))
        else $error("decode did not enter exactly one execute sequence");

    idle_left_on_start_only: assert property (
        @(posedge clock) disable iff (reset)
        (state == state_idle && !start) |=> (state == state_idle))
        else $error("idle left without start");

endmodule

bind e100_control e100_checker checker_inst (
    .clock        (clock),
    .reset        (reset),
    .start        (start),
    .halted       (halted),
    .memory_write (memory_write),
    .state        (state)
);

`default_nettype wire

//--- test/e100_tb.sv
// e100 testbench: loads programs over the host port, runs them, checks memory against a model
`timescale 1ns/1ps
`default_nettype none

module e100_tb;

    import e100_pkg::*;

    localparam int halt_timeout = 5000;

    logic     clock;
    logic     reset;
    logic     start;
    logic     host_write;
    address_t host_address;
    word_t    host_write_data;
    word_t    host_read_data;
    logic     halted;

    // program image, model memory and what came back from the DUT
    word_t image [memory_words];
    word_t ref_mem [memory_words];
    word_t read_back [memory_words];

    word_t seed;
    int    next_pc;
    int    test_number;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;
    logic  compare_pending;
    event  compare_start;

    e100_clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    e100_top e100_top_inst (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .host_write      (host_write),
        .host_address    (host_address),
        .host_write_data (host_write_data),
        .host_read_data  (host_read_data),
        .halted          (halted)
    );

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t random_word();
        seed = lcg_next(seed);
        return seed;
    endfunction

    // background words, every address bit shows up
    function automatic word_t fill_word(input address_t a);
        return {a, ~a, a ^ 8'h5a, a + 8'd17};
    endfunction

    function automatic void clear_image();
        for (int i = 0; i < memory_words; i++) begin
            image[i] = fill_word(address_t'(i));
        end
        next_pc = 0;
    endfunction

    function automatic void emit(input word_t op, input word_t a1, input word_t a2,
                                 input word_t a3);
        image[next_pc] = op;
        image[next_pc + 1] = a1;
        image[next_pc + 2] = a2;
        image[next_pc + 3] = a3;
        next_pc = next_pc + instruction_words;
    endfunction

    // instruction-level model of the machine over ref_mem
    function automatic void run_reference();
        int    pc;
        int    steps;
        logic  running;
        word_t op;
        word_t a1;
        word_t v2;
        word_t v3;
        pc = 0;
        steps = 0;
        running = 1'b1;
        while (running && steps < 100000) begin
            op = ref_mem[pc % memory_words];
            a1 = ref_mem[(pc + 1) % memory_words];
            v2 = ref_mem[ref_mem[(pc + 2) % memory_words][address_width-1:0]];
            v3 = ref_mem[ref_mem[(pc + 3) % memory_words][address_width-1:0]];
            pc = pc + instruction_words;
            steps++;
            case (op)
                op_add: ref_mem[a1[address_width-1:0]] = v2 + v3;
                op_sub: ref_mem[a1[address_width-1:0]] = v2 - v3;
                op_and: ref_mem[a1[address_width-1:0]] = v2 & v3;
                op_or:  ref_mem[a1[address_width-1:0]] = v2 | v3;
                op_not: ref_mem[a1[address_width-1:0]] = ~v2;
                op_cp:  ref_mem[a1[address_width-1:0]] = v2;
                op_sl:  ref_mem[a1[address_width-1:0]] = (v3 >= 32) ? '0 : v2 << v3[4:0];
                op_sr:  ref_mem[a1[address_width-1:0]] = (v3 >= 32) ? '0 : v2 >> v3[4:0];
                op_be:  if (v2 == v3) pc = int'(a1[address_width-1:0]);
                op_bne: if (v2 != v3) pc = int'(a1[address_width-1:0]);
                op_blt: if (v2 < v3) pc = int'(a1[address_width-1:0]);
                default: running = 1'b0;
            endcase
        end
    endfunction

    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (reset && cycles < 20) begin
            @(negedge clock);
            cycles++;
        end
        if (reset) begin
            $display("reset was never released");
            test_errors++;
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < memory_words; i++) begin
            @(posedge clock);
            #1;
            host_write = 1'b1;
            host_address = address_t'(i);
            host_write_data = image[i];
        end
        @(posedge clock);
        #1;
        host_write = 1'b0;
    endtask

    task automatic read_memory();
        for (int i = 0; i < memory_words; i++) begin
            @(posedge clock);
            #1;
            host_address = address_t'(i);
            @(negedge clock);
            read_back[i] = host_read_data;
        end
    endtask

    task automatic pulse_start();
        @(posedge clock);
        #1;
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_for_halt(input string what);
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < halt_timeout) begin
            @(negedge clock);
            done = halted;
            cycles++;
        end
        if (!done) begin
            $display("timeout: processor did not halt within %0d cycles (%s)",
                     halt_timeout, what);
            test_errors++;
        end
    endtask

    // hand the read-back words to the comparing process
    task automatic check_memory();
        int waited;
        waited = 0;
        compare_pending = 1'b1;
        -> compare_start;
        while (compare_pending && waited < 10) begin
            #1;
            waited++;
        end
        if (compare_pending) begin
            $display("memory comparison did not complete");
            test_errors++;
            compare_pending = 1'b0;
        end
    endtask

    task automatic run_program(input string name);
        ref_mem = image;
        run_reference();
        load_memory();
        pulse_start();
        wait_for_halt(name);
        read_memory();
        check_memory();
    endtask

    task automatic finish_test(input string name);
        test_number++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: passed", test_number, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_number, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        forever begin
            @(compare_start);
            for (int i = 0; i < memory_words; i++) begin
                assert (read_back[i] === ref_mem[i])
                else begin
                    $display("FAILED host_read_data at %02h: expected %08h, got %08h",
                             i, ref_mem[i], read_back[i]);
                    test_errors++;
                end
            end
            compare_pending = 1'b0;
        end
    end

    initial begin
        start = 1'b0;
        host_write = 1'b0;
        host_address = '0;
        host_write_data = '0;
        seed = 32'd66466;
        next_pc = 0;
        test_number = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        compare_pending = 1'b0;
        wait_for_reset_release();

        assert (halted === 1'b1)
        else begin
            $display("halted is not high after reset");
            test_errors++;
        end
        clear_image();
        ref_mem = image;
        load_memory();
        read_memory();
        check_memory();
        finish_test("reset and host load");

        // shifts by a small amount, exactly 32, above 32 and a huge amount
        clear_image();
        for (int i = 0; i < 8; i++) begin
            image[8'h80 + i] = random_word();
        end
        image[8'h88] = random_word() & 32'h1f;
        image[8'h89] = 32'd32;
        image[8'h8a] = 32'd33 + (random_word() & 32'h3f);
        image[8'h8b] = random_word() | 32'h8000_0000;
        emit(op_add, 32'ha0, 32'h80, 32'h81);
        emit(op_sub, 32'ha1, 32'h82, 32'h83);
        emit(op_and, 32'ha2, 32'h84, 32'h85);
        emit(op_or, 32'ha3, 32'h86, 32'h87);
        emit(op_sl, 32'ha4, 32'h80, 32'h88);
        emit(op_sl, 32'ha5, 32'h81, 32'h89);
        emit(op_sr, 32'ha6, 32'h82, 32'h88);
        emit(op_sr, 32'ha7, 32'h83, 32'h8a);
        emit(op_sl, 32'ha8, 32'h84, 32'h8b);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        run_program("alu operations");
        finish_test("alu operations");

        clear_image();
        image[8'h80] = random_word();
        image[8'h81] = random_word();
        image[8'h8c] = 32'd0;
        emit(op_not, 32'ha0, 32'h80, 32'd0);
        emit(op_not, 32'ha1, 32'h8c, 32'd0);
        emit(op_cp, 32'ha2, 32'h81, 32'd0);
        emit(op_cp, 32'ha3, 32'ha0, 32'd0);
        emit(op_not, 32'ha4, 32'ha3, 32'd0);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        run_program("not and cp");
        finish_test("not and cp");

        // countdown at 0x80, one at 0x81, zero at 0x82, iterations at 0x83
        clear_image();
        image[8'h80] = 32'd3 + (random_word() & 32'h3);
        image[8'h81] = 32'd1;
        image[8'h82] = 32'd0;
        image[8'h83] = 32'd0;
        emit(op_sub, 32'h80, 32'h80, 32'h81);
        emit(op_add, 32'h83, 32'h83, 32'h81);
        emit(op_bne, 32'd0, 32'h80, 32'h82);
        emit(op_blt, 32'd24, 32'h82, 32'h81);
        emit(op_cp, 32'h90, 32'h81, 32'd0);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        emit(op_blt, 32'd0, 32'h81, 32'h82);
        emit(op_be, 32'd40, 32'h80, 32'h82);
        emit(op_cp, 32'h91, 32'h81, 32'd0);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        emit(op_cp, 32'h92, 32'h81, 32'd0);
        emit(op_be, 32'd0, 32'h81, 32'h82);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        run_program("branch loop");
        finish_test("branch loop");

        clear_image();
        image[8'h80] = random_word();
        image[8'h81] = random_word();
        emit(op_add, 32'ha0, 32'h80, 32'h81);
        emit(32'd3, 32'ha1, 32'h80, 32'h81);
        emit(op_cp, 32'ha2, 32'h80, 32'd0);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        run_program("undefined opcode");
        finish_test("undefined opcode");

        // each run bumps 0x80 once, then spins a short loop
        clear_image();
        image[8'h80] = random_word();
        image[8'h81] = 32'd1;
        image[8'h83] = 32'd0;
        image[8'h84] = 32'd12;
        emit(op_add, 32'h80, 32'h80, 32'h81);
        emit(op_cp, 32'h82, 32'h84, 32'd0);
        emit(op_sub, 32'h82, 32'h82, 32'h81);
        emit(op_bne, 32'd8, 32'h82, 32'h83);
        emit(op_halt, 32'd0, 32'd0, 32'd0);
        ref_mem = image;
        run_reference();
        run_reference();
        load_memory();
        pulse_start();
        repeat (20) @(negedge clock);
        assert (halted === 1'b0)
        else begin
            $display("processor stopped before the host write was issued");
            test_errors++;
        end
        @(posedge clock);
        #1;
        host_write = 1'b1;
        host_address = 8'h80;
        host_write_data = ~image[8'h80];
        @(posedge clock);
        #1;
        host_write = 1'b0;
        wait_for_halt("first run");
        pulse_start();
        wait_for_halt("second run");
        read_memory();
        check_memory();
        finish_test("host write while running and restart");

        $display("tests %0d, passed %0d, failed %0d", test_number, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/e100_pkg.sv
hdl/e100_memory.sv
hdl/e100_control.sv
hdl/e100_datapath.sv
hdl/e100_top.sv
test/e100_clock_gen.sv
test/e100_checker.sv
test/e100_tb.sv

//--- run.sh
#!/bin/sh
# build the e100 testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module e100_tb -f flist.f -o e100_sim

output=$(./obj_dir/e100_sim)
echo "$output"
echo "$output" | grep -qx "Everything OK"
